/* logic/mem_test_pkg.sv */
// Memory tester shared definitions
// Bus and counter widths, the word stride, the pattern LFSR taps and the control states
`default_nettype none

package mem_test_pkg;

    // Avalon-MM byte address and data word widths
    localparam int ADDR_WIDTH = 32;
    localparam int DATA_WIDTH = 32;

    // Word count from the host and error count to the host share this width
    localparam int COUNT_WIDTH = 16;

    // Byte increment from one tested word to the next
    localparam int ADDR_STEP = 4;

    // Galois feedback mask, applied whenever a 1 is shifted out of bit 0
    localparam logic [DATA_WIDTH-1:0] LFSR_TAPS = 32'h8020_0003;

    // Sequencer states, one write and one read per word followed by a single step cycle
    typedef enum logic [2:0] {
        IDLE,
        WRITE,
        READ,
        STEP,
        DONE
    } test_state_t;

endpackage

`default_nettype wire

/* logic/mem_test_control.sv */
// Memory tester sequencer
// Runs the host req/ack handshake and walks each word through write, read and step
`default_nettype none

module mem_test_control (
    input  logic                               clk,
    input  logic                               reset,
    input  logic                               run_req,
    output logic                               run_ack,
    input  logic [mem_test_pkg::COUNT_WIDTH-1:0] word_count,
    input  logic                               write_complete,
    input  logic                               read_complete,
    output logic                               wr_en,
    output logic                               rd_en,
    output logic                               load,
    output logic                               step
);

    import mem_test_pkg::*;

    test_state_t state;

    // Words still to be tested in this run, including the current one
    logic [COUNT_WIDTH-1:0] remaining;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state     <= IDLE;
            remaining <= '0;
        end else begin
            case (state)
                IDLE: begin
                    // A zero count skips straight to the acknowledge with no bus traffic
                    if (run_req) begin
                        remaining <= word_count;
                        state     <= (word_count == '0) ? DONE : WRITE;
                    end
                end
                WRITE: begin
                    if (write_complete) begin
                        state <= READ;
                    end
                end
                READ: begin
                    if (read_complete) begin
                        state <= STEP;
                    end
                end
                STEP: begin
                    remaining <= remaining - 1'b1;
                    // The last word has just been checked
                    state     <= (remaining == COUNT_WIDTH'(1)) ? DONE : WRITE;
                end
                DONE: begin
                    // Hold the acknowledge until the host lets go of the request
                    if (!run_req) begin
                        state <= IDLE;
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    // The enables are levels that last for the whole state
    assign wr_en   = (state == WRITE);
    assign rd_en   = (state == READ);
    assign step    = (state == STEP);
    assign run_ack = (state == DONE);

    // Load fires in the single cycle that leaves IDLE, so the datapath is ready in WRITE
    assign load = (state == IDLE) && run_req;

endmodule

`default_nettype wire

/* logic/pattern_gen.sv */
// Address and pattern generator
// Holds the word address and a Galois LFSR that gives the expected data for each word
`default_nettype none

module pattern_gen (
    input  logic                                 clk,
    input  logic                                 reset,
    input  logic                                 load,
    input  logic                                 step,
    input  logic [mem_test_pkg::ADDR_WIDTH-1:0]  base_address,
    input  logic [mem_test_pkg::DATA_WIDTH-1:0]  seed,
    output logic [mem_test_pkg::ADDR_WIDTH-1:0]  address,
    output logic [mem_test_pkg::DATA_WIDTH-1:0]  expected_data
);

    import mem_test_pkg::*;

    logic [DATA_WIDTH-1:0] lfsr_next;
    logic [DATA_WIDTH-1:0] lfsr_load;

    // One right shift, folding the taps back in when the dropped bit is set
    assign lfsr_next = (expected_data >> 1) ^ (expected_data[0] ? LFSR_TAPS : '0);

    // An all-zero state would lock the LFSR, so a zero seed starts from 1
    assign lfsr_load = (seed == '0) ? DATA_WIDTH'(1) : seed;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            address       <= '0;
            expected_data <= DATA_WIDTH'(1);
        end else if (load) begin
            address       <= base_address;
            expected_data <= lfsr_load;
        end else if (step) begin
            address       <= address + ADDR_WIDTH'(ADDR_STEP);
            expected_data <= lfsr_next;
        end
    end

endmodule

`default_nettype wire

/* logic/read_checker.sv */
// Read-back checker
// Compares each read word with the expected pattern and keeps the run's error results
`default_nettype none

module read_checker (
    input  logic                                  clk,
    input  logic                                  reset,
    input  logic                                  clear,
    input  logic                                  read_complete,
    input  logic [mem_test_pkg::DATA_WIDTH-1:0]   read_data,
    input  logic [mem_test_pkg::DATA_WIDTH-1:0]   expected_data,
    input  logic [mem_test_pkg::ADDR_WIDTH-1:0]   address,
    output logic [mem_test_pkg::COUNT_WIDTH-1:0]  error_count,
    output logic [mem_test_pkg::ADDR_WIDTH-1:0]   first_fail_address,
    output logic                                  any_fail
);

    logic mismatch;

    // Only the cycle of read_complete carries valid read data
    assign mismatch = read_complete && (read_data != expected_data);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            error_count        <= '0;
            first_fail_address <= '0;
            any_fail           <= 1'b0;
        end else if (clear) begin
            // A new run starts from a clean result set
            error_count        <= '0;
            first_fail_address <= '0;
            any_fail           <= 1'b0;
        end else if (mismatch) begin
            // The count sticks at all ones rather than wrapping back to a pass
            if (!(&error_count)) begin
                error_count <= error_count + 1'b1;
            end
            // Only the first failure of the run is recorded
            if (!any_fail) begin
                any_fail           <= 1'b1;
                first_fail_address <= address;
            end
        end
    end

endmodule

`default_nettype wire

/* logic/avalon_master.sv */
// Avalon-MM master adapter
// Turns level read and write enables into single bus transfers with one-cycle completion pulses
`default_nettype none

module avalon_master (
    input  logic                                 clk,
    input  logic                                 reset,
    input  logic                                 wr_en,
    input  logic                                 rd_en,
    input  logic [mem_test_pkg::ADDR_WIDTH-1:0]  address,
    input  logic [mem_test_pkg::DATA_WIDTH-1:0]  write_data,
    output logic                                 write_complete,
    output logic                                 read_complete,
    output logic [mem_test_pkg::DATA_WIDTH-1:0]  read_data,
    output logic [mem_test_pkg::ADDR_WIDTH-1:0]  avm_address,
    output logic                                 avm_write,
    output logic                                 avm_read,
    output logic [mem_test_pkg::DATA_WIDTH-1:0]  avm_writedata,
    input  logic                                 avm_waitrequest,
    input  logic [mem_test_pkg::DATA_WIDTH-1:0]  avm_readdata,
    input  logic                                 avm_readdatavalid
);

    typedef enum logic [1:0] {IDLE, CMD, WAIT_DATA, HOLD} master_state_t;

    master_state_t state;

    // Which enable the current or last transfer answered
    logic is_read;
    logic served_en;
    logic can_accept;

    assign served_en = is_read ? rd_en : wr_en;

    // In HOLD the old enable must drop first, which keeps one request from running twice
    assign can_accept = (state == IDLE) || ((state == HOLD) && !served_en);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state          <= IDLE;
            is_read        <= 1'b0;
            avm_write      <= 1'b0;
            avm_read       <= 1'b0;
            write_complete <= 1'b0;
            read_complete  <= 1'b0;
        end else begin
            write_complete <= 1'b0;
            read_complete  <= 1'b0;
            case (state)
                IDLE, HOLD: begin
                    if (can_accept) begin
                        // Write wins if both are up, though the sequencer never does that
                        if (wr_en) begin
                            avm_write <= 1'b1;
                            is_read   <= 1'b0;
                            state     <= CMD;
                        end else if (rd_en) begin
                            avm_read <= 1'b1;
                            is_read  <= 1'b1;
                            state    <= CMD;
                        end else begin
                            state <= IDLE;
                        end
                    end
                end
                CMD: begin
                    // The command stays on the bus until the slave stops stalling
                    if (!avm_waitrequest) begin
                        if (is_read) begin
                            avm_read <= 1'b0;
                            state    <= WAIT_DATA;
                        end else begin
                            avm_write      <= 1'b0;
                            write_complete <= 1'b1;
                            state          <= HOLD;
                        end
                    end
                end
                WAIT_DATA: begin
                    if (avm_readdatavalid) begin
                        read_complete <= 1'b1;
                        state         <= HOLD;
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    // Address, write data and read data are plain payload registers
    always_ff @(posedge clk) begin
        if (can_accept && (wr_en || rd_en)) begin
            avm_address   <= address;
            avm_writedata <= write_data;
        end
        if ((state == WAIT_DATA) && avm_readdatavalid) begin
            read_data <= avm_readdata;
        end
    end

endmodule

`default_nettype wire

/* logic/mem_test_top.sv */
// Memory tester top level
// Joins the sequencer, pattern generator, checker and Avalon master to the host and bus ports
`default_nettype none

module mem_test_top (
    input  logic                                  clk,
    input  logic                                  reset,
    // Host side, four-phase handshake
    input  logic                                  run_req,
    output logic                                  run_ack,
    input  logic [mem_test_pkg::ADDR_WIDTH-1:0]   base_address,
    input  logic [mem_test_pkg::COUNT_WIDTH-1:0]  word_count,
    input  logic [mem_test_pkg::DATA_WIDTH-1:0]   seed,
    output logic [mem_test_pkg::COUNT_WIDTH-1:0]  error_count,
    output logic [mem_test_pkg::ADDR_WIDTH-1:0]   first_fail_address,
    output logic                                  any_fail,
    // Avalon-MM master side
    output logic [mem_test_pkg::ADDR_WIDTH-1:0]   avm_address,
    output logic                                  avm_write,
    output logic                                  avm_read,
    output logic [mem_test_pkg::DATA_WIDTH-1:0]   avm_writedata,
    input  logic                                  avm_waitrequest,
    input  logic [mem_test_pkg::DATA_WIDTH-1:0]   avm_readdata,
    input  logic                                  avm_readdatavalid
);

    import mem_test_pkg::*;

    // Sequencer controls
    logic wr_en;
    logic rd_en;
    logic load;
    logic step;

    // Completion pulses from the master
    logic write_complete;
    logic read_complete;

    // Datapath words
    logic [ADDR_WIDTH-1:0] address;
    logic [DATA_WIDTH-1:0] expected_data;
    logic [DATA_WIDTH-1:0] read_data;

    mem_test_control u_control (
        .clk            (clk),
        .reset          (reset),
        .run_req        (run_req),
        .run_ack        (run_ack),
        .word_count     (word_count),
        .write_complete (write_complete),
        .read_complete  (read_complete),
        .wr_en          (wr_en),
        .rd_en          (rd_en),
        .load           (load),
        .step           (step)
    );

    pattern_gen u_pattern (
        .clk           (clk),
        .reset         (reset),
        .load          (load),
        .step          (step),
        .base_address  (base_address),
        .seed          (seed),
        .address       (address),
        .expected_data (expected_data)
    );

    // The load pulse also wipes the previous run's results
    read_checker u_checker (
        .clk                (clk),
        .reset              (reset),
        .clear              (load),
        .read_complete      (read_complete),
        .read_data          (read_data),
        .expected_data      (expected_data),
        .address            (address),
        .error_count        (error_count),
        .first_fail_address (first_fail_address),
        .any_fail           (any_fail)
    );

    // The expected word doubles as the write data
    avalon_master u_master (
        .clk               (clk),
        .reset             (reset),
        .wr_en             (wr_en),
        .rd_en             (rd_en),
        .address           (address),
        .write_data        (expected_data),
        .write_complete    (write_complete),
        .read_complete     (read_complete),
        .read_data         (read_data),
        .avm_address       (avm_address),
        .avm_write         (avm_write),
        .avm_read          (avm_read),
        .avm_writedata     (avm_writedata),
        .avm_waitrequest   (avm_waitrequest),
        .avm_readdata      (avm_readdata),
        .avm_readdatavalid (avm_readdatavalid)
    );

endmodule

`default_nettype wire

/* bench/avalon_mem_model.sv */
// Behavioral Avalon-MM memory
// Random wait states and read latency, with stuck bits forced on writes to one address
`default_nettype none

module avalon_mem_model (
    input  logic                                 clk,
    input  logic                                 reset,
    input  logic [mem_test_pkg::ADDR_WIDTH-1:0]  avm_address,
    input  logic                                 avm_write,
    input  logic                                 avm_read,
    input  logic [mem_test_pkg::DATA_WIDTH-1:0]  avm_writedata,
    output logic                                 avm_waitrequest,
    output logic [mem_test_pkg::DATA_WIDTH-1:0]  avm_readdata,
    output logic                                 avm_readdatavalid,
    input  logic [mem_test_pkg::ADDR_WIDTH-1:0]  fault_address,
    input  logic [mem_test_pkg::DATA_WIDTH-1:0]  fault_mask,
    input  logic [mem_test_pkg::DATA_WIDTH-1:0]  fault_value
);

    import mem_test_pkg::*;

    // 1024 words cover byte addresses up to 0xFFC, higher address bits alias
    logic [DATA_WIDTH-1:0] mem [0:1023];
    logic [2:0]            wait_left;
    logic [2:0]            latency_left;
    logic                  read_pending;
    logic [ADDR_WIDTH-1:0] read_address;
    logic [DATA_WIDTH-1:0] stored_word;
    logic                  command;

    assign command = avm_write || avm_read;

    // The slave stalls a new command for the wait states drawn while the bus was idle
    assign avm_waitrequest = command && (wait_left != 3'd0);

    // Masked bits at the faulty address keep the stuck value whatever is written
    assign stored_word = (avm_address == fault_address) ?
        ((avm_writedata & ~fault_mask) | (fault_value & fault_mask)) : avm_writedata;

    always @(posedge clk or posedge reset) begin
        if (reset) begin
            wait_left         <= 3'd0;
            latency_left      <= 3'd0;
            read_pending      <= 1'b0;
            read_address      <= '0;
            avm_readdata      <= '0;
            avm_readdatavalid <= 1'b0;
        end else begin
            avm_readdatavalid <= 1'b0;
            if (!command) begin
                wait_left <= 3'($urandom_range(3, 0));
            end else if (wait_left != 3'd0) begin
                wait_left <= wait_left - 3'd1;
            end else if (avm_write) begin
                mem[avm_address[11:2]] <= stored_word;
            end else begin
                // Accepted read, the data returns after a random number of cycles
                read_pending <= 1'b1;
                read_address <= avm_address;
                latency_left <= 3'($urandom_range(4, 0));
            end
            if (read_pending) begin
                if (latency_left == 3'd0) begin
                    avm_readdata      <= mem[read_address[11:2]];
                    avm_readdatavalid <= 1'b1;
                    read_pending      <= 1'b0;
                end else begin
                    latency_left <= latency_left - 3'd1;
                end
            end
        end
    end

endmodule

`default_nettype wire

/* bench/mem_test_tb.sv */
// Memory tester testbench
// Replays the runs of the tests file against a behavioral Avalon memory and checks each result
`default_nettype none

module mem_test_tb;

    import mem_test_pkg::*;

    localparam int NUM_TESTS = 16;
    localparam int FIELDS = 9;
    localparam int TIMEOUT_CYCLES = 50000;

    logic                   clk;
    logic                   reset;
    logic                   run_req;
    logic                   run_ack;
    logic [ADDR_WIDTH-1:0]  base_address;
    logic [COUNT_WIDTH-1:0] word_count;
    logic [DATA_WIDTH-1:0]  seed;
    logic [COUNT_WIDTH-1:0] error_count;
    logic [ADDR_WIDTH-1:0]  first_fail_address;
    logic                   any_fail;
    logic [ADDR_WIDTH-1:0]  avm_address;
    logic                   avm_write;
    logic                   avm_read;
    logic [DATA_WIDTH-1:0]  avm_writedata;
    logic                   avm_waitrequest;
    logic [DATA_WIDTH-1:0]  avm_readdata;
    logic                   avm_readdatavalid;
    logic [ADDR_WIDTH-1:0]  fault_address;
    logic [DATA_WIDTH-1:0]  fault_mask;
    logic [DATA_WIDTH-1:0]  fault_value;

    logic [31:0] test_words [0:NUM_TESTS*FIELDS-1];

    // Bus tracking for the run in progress with the next expected word and the transfer counts
    logic [ADDR_WIDTH-1:0]  track_address;
    logic [DATA_WIDTH-1:0]  track_data;
    logic [COUNT_WIDTH-1:0] writes_seen;
    logic [COUNT_WIDTH-1:0] reads_seen;

    // Command that the slave stalled at the last falling edge
    logic                   stall_write;
    logic                   stall_read;
    logic [ADDR_WIDTH-1:0]  stall_address;

    mem_test_top UUT (
        .clk                (clk),
        .reset              (reset),
        .run_req            (run_req),
        .run_ack            (run_ack),
        .base_address       (base_address),
        .word_count         (word_count),
        .seed               (seed),
        .error_count        (error_count),
        .first_fail_address (first_fail_address),
        .any_fail           (any_fail),
        .avm_address        (avm_address),
        .avm_write          (avm_write),
        .avm_read           (avm_read),
        .avm_writedata      (avm_writedata),
        .avm_waitrequest    (avm_waitrequest),
        .avm_readdata       (avm_readdata),
        .avm_readdatavalid  (avm_readdatavalid)
    );

    avalon_mem_model memory (
        .clk               (clk),
        .reset             (reset),
        .avm_address       (avm_address),
        .avm_write         (avm_write),
        .avm_read          (avm_read),
        .avm_writedata     (avm_writedata),
        .avm_waitrequest   (avm_waitrequest),
        .avm_readdata      (avm_readdata),
        .avm_readdatavalid (avm_readdatavalid),
        .fault_address     (fault_address),
        .fault_mask        (fault_mask),
        .fault_value       (fault_value)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #4 clk = ~clk;
        end
    end

    task automatic stop_with_failure(input string reason);
        $display("%s", reason);
        $display("Sequencer state at the failure: %s", UUT.u_control.state.name());
        $display("ERRORS FOUND");
        $fatal(1, "Simulation stopped at the first failure");
    endtask

    task automatic check_count(input logic [COUNT_WIDTH-1:0] got,
                               input logic [COUNT_WIDTH-1:0] expected, input string what);
        if (got !== expected) begin
            stop_with_failure($sformatf("Fail at time %0t: %s expected %0d, got %0d",
                                        $time, what, expected, got));
        end
    endtask

    task automatic check_address(input logic [ADDR_WIDTH-1:0] got,
                                 input logic [ADDR_WIDTH-1:0] expected, input string what);
        if (got !== expected) begin
            stop_with_failure($sformatf("Fail at time %0t: %s expected %h, got %h",
                                        $time, what, expected, got));
        end
    endtask

    task automatic check_data(input logic [DATA_WIDTH-1:0] got,
                              input logic [DATA_WIDTH-1:0] expected, input string what);
        if (got !== expected) begin
            stop_with_failure($sformatf("Fail at time %0t: %s expected %h, got %h",
                                        $time, what, expected, got));
        end
    endtask

    task automatic check_flag(input logic got, input logic expected, input string what);
        if (got !== expected) begin
            stop_with_failure($sformatf("Fail at time %0t: %s expected %b, got %b",
                                        $time, what, expected, got));
        end
    endtask

    // One Galois right shift that folds the taps back in when a 1 drops out of bit 0
    function automatic logic [DATA_WIDTH-1:0] next_pattern(input logic [DATA_WIDTH-1:0] value);
        logic [DATA_WIDTH-1:0] shifted;
        shifted = value >> 1;
        if (value[0]) begin
            shifted = shifted ^ LFSR_TAPS;
        end
        return shifted;
    endfunction

    // A transfer stable on the falling edge with waitrequest low is accepted at the next rise
    task automatic watch_bus();
        // A command stalled at the last falling edge is still on the bus with the same address
        if (stall_write || stall_read) begin
            check_flag(avm_write, stall_write, "avm_write held under waitrequest");
            check_flag(avm_read, stall_read, "avm_read held under waitrequest");
            check_address(avm_address, stall_address, "avm_address held under waitrequest");
        end
        stall_write   = avm_write && avm_waitrequest;
        stall_read    = avm_read && avm_waitrequest;
        stall_address = avm_address;
        if (avm_write && !avm_waitrequest) begin
            check_count(writes_seen, reads_seen, "writes before this write");
            check_address(avm_address, track_address, "write address");
            check_data(avm_writedata, track_data, "write data");
            writes_seen = writes_seen + 1'b1;
        end
        if (avm_read && !avm_waitrequest) begin
            check_count(writes_seen, COUNT_WIDTH'(reads_seen + 1'b1), "writes before this read");
            check_address(avm_address, track_address, "read address");
            reads_seen    = reads_seen + 1'b1;
            track_address = track_address + ADDR_WIDTH'(ADDR_STEP);
            track_data    = next_pattern(track_data);
        end
    endtask

    task automatic wait_for_ack(input logic level);
        int cycles;
        cycles = 0;
        while (run_ack !== level) begin
            @(negedge clk);
            watch_bus();
            cycles = cycles + 1;
            if (cycles > TIMEOUT_CYCLES) begin
                stop_with_failure($sformatf(
                    "The run handshake stalled: run_ack did not go to %0b within %0d cycles",
                    level, TIMEOUT_CYCLES));
            end
        end
    endtask

    task automatic do_run(input int index);
        int                     first;
        int                     i;
        logic [ADDR_WIDTH-1:0]  address;
        logic [DATA_WIDTH-1:0]  data;
        logic [DATA_WIDTH-1:0]  stored;
        logic [COUNT_WIDTH-1:0] exp_errors;
        logic [ADDR_WIDTH-1:0]  exp_first;
        first = index * FIELDS;
        @(negedge clk);
        seed          = test_words[first];
        base_address  = test_words[first+1];
        word_count    = test_words[first+2][COUNT_WIDTH-1:0];
        fault_address = test_words[first+3];
        fault_mask    = test_words[first+4];
        fault_value   = test_words[first+5];
        // Walk the words as the LFSR pattern defines them and start a zero seed from 1
        address    = base_address;
        data       = (seed == '0) ? DATA_WIDTH'(1) : seed;
        exp_errors = '0;
        exp_first  = '0;
        track_address = address;
        track_data    = data;
        writes_seen   = '0;
        reads_seen    = '0;
        for (i = 0; i < int'(word_count); i = i + 1) begin
            stored = (data & ~fault_mask) | (fault_value & fault_mask);
            if ((address == fault_address) && (stored != data)) begin
                if (exp_errors == '0) begin
                    exp_first = address;
                end
                exp_errors = exp_errors + 1'b1;
            end
            address = address + ADDR_WIDTH'(ADDR_STEP);
            data    = next_pattern(data);
        end
        check_count(test_words[first+6][COUNT_WIDTH-1:0], exp_errors, "tests file error count");
        check_address(test_words[first+7], exp_first, "tests file first failure");
        check_flag(test_words[first+8][0], exp_errors != '0, "tests file fail flag");
        check_flag(run_ack, 1'b0, "run_ack before run_req");
        @(negedge clk);
        run_req = 1'b1;
        wait_for_ack(1'b1);
        // The acknowledge and the results hold while the host keeps the request up
        repeat (3) begin
            check_flag(run_ack, 1'b1, "run_ack while run_req is high");
            check_count(error_count, exp_errors, "error_count");
            check_address(first_fail_address, exp_first, "first_fail_address");
            check_flag(any_fail, exp_errors != '0, "any_fail");
            @(negedge clk);
            watch_bus();
        end
        run_req = 1'b0;
        wait_for_ack(1'b0);
        repeat (3) begin
            @(negedge clk);
            watch_bus();
            check_flag(run_ack, 1'b0, "run_ack after run_req fell");
            check_count(error_count, exp_errors, "error_count after the handshake");
            check_address(first_fail_address, exp_first, "first_fail_address after the handshake");
            check_flag(any_fail, exp_errors != '0, "any_fail after the handshake");
        end
        check_count(writes_seen, word_count, "bus writes in the run");
        check_count(reads_seen, word_count, "bus reads in the run");
        $display("Run %0d: %0d words from %h, %0d errors, sequencer back in %s",
                 index, word_count, base_address, error_count, UUT.u_control.state.name());
    endtask

    initial begin
        void'($urandom(21388));
        reset         = 1'b1;
        run_req       = 1'b0;
        base_address  = '0;
        word_count    = '0;
        seed          = '0;
        fault_address = '0;
        fault_mask    = '0;
        fault_value   = '0;
        track_address = '0;
        track_data    = '0;
        writes_seen   = '0;
        reads_seen    = '0;
        stall_write   = 1'b0;
        stall_read    = 1'b0;
        stall_address = '0;
        $readmemh("bench/mem_test_tests.txt", test_words);
        repeat (10) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        check_flag(run_ack, 1'b0, "run_ack after reset");
        check_flag(avm_write, 1'b0, "avm_write after reset");
        check_flag(avm_read, 1'b0, "avm_read after reset");
        check_flag(any_fail, 1'b0, "any_fail after reset");
        check_count(error_count, '0, "error_count after reset");
        for (int t = 0; t < NUM_TESTS; t = t + 1) begin
            do_run(t);
        end
        $display("NO ERRORS");
        $finish;
    end

endmodule

`default_nettype wire

/* bench/mem_test_tests.txt */
// One run per line, all fields in hex:
// seed  base  count  fault_address  fault_mask  fault_value  errors  first_fail_address  any_fail
00000001 00000000 00000010 00000000 00000000 00000000 00000000 00000000 00000000
12345678 00000100 00000020 00000140 FFFFFFFF 00000000 00000001 00000140 00000001
00000001 00000200 00000008 00000204 80000000 00000000 00000001 00000204 00000001
00000001 00000200 00000008 00000204 80000000 80000000 00000000 00000000 00000000
00000000 00000300 00000004 00000300 00000001 00000001 00000000 00000000 00000000
00000000 00000300 00000004 00000300 00000001 00000000 00000001 00000300 00000001
12345678 00000100 00000020 00000140 FFFFFFFF 00000000 00000001 00000140 00000001
12345678 00000100 00000020 00000140 FFFFFFFF 00000000 00000001 00000140 00000001
0000ABCD 00000400 00000000 00000400 FFFFFFFF 00000000 00000000 00000000 00000000
CAFEF00D 00000800 00000040 00000900 FFFFFFFF 00000000 00000000 00000000 00000000
00000001 00000000 00000004 0000000C FFFFFFFF 0000FFFF 00000001 0000000C 00000001
DEADBEEF 00000A00 00000100 00000A00 0000FF00 00000000 00000001 00000A00 00000001
00000001 00000000 00000004 00000008 00000002 00000002 00000000 00000000 00000000
00000001 00000000 00000004 00000010 FFFFFFFF 00000000 00000000 00000000 00000000
FFFFFFFF 00000C00 00000020 00000000 00000000 00000000 00000000 00000000 00000000
00000001 00000200 00000008 00000204 80000000 00000000 00000001 00000204 00000001

/* mem_test_top.f */
logic/mem_test_pkg.sv
logic/mem_test_control.sv
logic/pattern_gen.sv
logic/read_checker.sv
logic/avalon_master.sv
logic/mem_test_top.sv
bench/avalon_mem_model.sv
bench/mem_test_tb.sv

/* Makefile */
TOP := mem_test_tb

.PHONY: all run lint clean

all: run

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP)

obj_dir/V$(TOP): mem_test_top.f $(wildcard logic/*.sv) $(wildcard bench/*.sv)
	verilator --binary --timing -Wno-fatal --top-module $(TOP) -f mem_test_top.f

lint:
	verilator --lint-only -Wall --top-module mem_test_top \
		logic/mem_test_pkg.sv logic/mem_test_control.sv logic/pattern_gen.sv \
		logic/read_checker.sv logic/avalon_master.sv logic/mem_test_top.sv

clean:
	rm -rf obj_dir
